// File: sim.f
e1000_pkg.sv
e1000_regs.sv
intr_ctrl.sv
shift_mdio.sv
e1000_top.sv
tb_e1000.sv

// File: Bender.yml
package:
  name: e1000_regs

sources:
  - e1000_pkg.sv
  - e1000_regs.sv
  - intr_ctrl.sv
  - shift_mdio.sv
  - e1000_top.sv
  - target: simulation
    files:
      - tb_e1000.sv

// File: tb_e1000.sv
module tb_e1000
	import e1000_pkg::*;
();

	localparam int WAIT_LIMIT = 50;
	localparam int POLL_LIMIT = 400;

	logic                     aclk;
	logic                     reset_i;
	logic [AXIL_ADDR_W-1:0]   s_awaddr_i;
	logic                     s_awvalid_i;
	logic                     s_awready_o;
	logic [AXIL_DATA_W-1:0]   s_wdata_i;
	logic [AXIL_DATA_W/8-1:0] s_wstrb_i;
	logic                     s_wvalid_i;
	logic                     s_wready_o;
	logic [1:0]               s_bresp_o;
	logic                     s_bvalid_o;
	logic                     s_bready_i;
	logic [AXIL_ADDR_W-1:0]   s_araddr_i;
	logic                     s_arvalid_i;
	logic                     s_arready_o;
	logic [AXIL_DATA_W-1:0]   s_rdata_o;
	logic [1:0]               s_rresp_o;
	logic                     s_rvalid_o;
	logic                     s_rready_i;
	logic                     intr_request_o;
	logic                     reset_request_o;
	logic                     phy_mdc_o;
	logic                     phy_mdio_i;
	logic                     phy_mdio_o;
	logic                     phy_mdio_oe_o;
	logic                     phy_mdio_req_o;
	logic                     phy_mdio_gnt_i;
	logic                     phy_int_i;
	logic                     phy_lsc_i;
	logic                     phy_reset_o;
	logic [1:0]               phy_speed_i;
	logic                     phy_duplex_i;
	logic                     phy_up_i;

	integer      seed;
	logic [15:0] phy_regs [32]; // PHY register contents seen over MDIO
	logic [63:0] last_frame;
	int          frame_count;

	e1000_top e1000_top_inst (.*);

	initial begin
		aclk = 1'b0;
		forever #20 aclk = ~aclk;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected)
		else abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge aclk);
			#2;
		end
	endtask

	// Stall holds bready low for that many cycles once the write is accepted
	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data, input int stall);
		int   cnt;
		logic hs;
		s_awaddr_i  = addr;
		s_wdata_i   = data;
		s_awvalid_i = 1'b1;
		s_wvalid_i  = 1'b1;
		s_bready_i  = (stall == 0);
		cnt = 0;
		hs  = 1'b0;
		while (!hs) begin
			#1;
			hs = s_awready_o & s_wready_o;
			@(posedge aclk);
			#2;
			cnt++;
			if (!hs && cnt > WAIT_LIMIT)
				abort_run("Timeout: write address and data were never accepted");
		end
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		idle_cycles(stall);
		s_bready_i = 1'b1;
		cnt = 0;
		hs  = 1'b0;
		while (!hs) begin
			#1;
			hs = s_bvalid_o;
			if (hs)
				check_value("write response", s_bresp_o, 2'b00);
			@(posedge aclk);
			#2;
			cnt++;
			if (!hs && cnt > WAIT_LIMIT)
				abort_run("Timeout: no write response arrived");
		end
	endtask

	task automatic read_reg(input logic [31:0] addr, output logic [31:0] data, input int stall);
		int   cnt;
		logic hs;
		s_araddr_i  = addr;
		s_arvalid_i = 1'b1;
		s_rready_i  = (stall == 0);
		cnt = 0;
		hs  = 1'b0;
		while (!hs) begin
			#1;
			hs = s_arready_o;
			@(posedge aclk);
			#2;
			cnt++;
			if (!hs && cnt > WAIT_LIMIT)
				abort_run("Timeout: read address was never accepted");
		end
		s_arvalid_i = 1'b0;
		idle_cycles(stall);
		s_rready_i = 1'b1;
		cnt = 0;
		hs  = 1'b0;
		while (!hs) begin
			#1;
			hs   = s_rvalid_o;
			data = s_rdata_o;
			if (hs)
				check_value("read response", s_rresp_o, 2'b00);
			@(posedge aclk);
			#2;
			cnt++;
			if (!hs && cnt > WAIT_LIMIT)
				abort_run("Timeout: no read data arrived");
		end
	endtask

	task automatic wait_mdic_ready(output logic [31:0] mdic);
		int polls;
		polls = 0;
		read_reg(REG_MDIC, mdic, 0);
		while (!mdic[MDIC_RDY_BIT]) begin
			polls++;
			if (polls > POLL_LIMIT)
				abort_run("Timeout: MDIC ready bit never came back");
			read_reg(REG_MDIC, mdic, 0);
		end
	endtask

	function automatic logic [31:0] mdic_word(input logic [1:0] op, input logic [4:0] regad,
			input logic [15:0] data);
		return {4'b0, op, 5'd3, regad, data}; // PHY address 3 must not reach the frame
	endfunction

	function automatic logic [31:0] status_word(input logic [1:0] speed, input logic up,
			input logic duplex);
		return {24'h0, speed, 4'h0, up, duplex};
	endfunction

	// Grant follows the request by two cycles
	initial begin : phy_grant
		logic [1:0] req_hist;
		phy_mdio_gnt_i = 1'b0;
		req_hist = '0;
		forever begin
			@(posedge aclk);
			#1;
			req_hist = {req_hist[0], phy_mdio_req_o};
			#1;
			phy_mdio_gnt_i = &req_hist;
		end
	end

	// 32 preamble bits then the 32-bit frame with one bit per MDC rise
	initial begin : phy_frame
		logic [63:0] bits;
		logic        rd_op;
		logic [4:0]  regad;
		phy_mdio_i  = 1'b0;
		frame_count = 0;
		bits        = '0;
		regad       = '0;
		forever begin
			@(posedge phy_mdio_req_o);
			rd_op = 1'b0;
			for (int r = 0; r < 64; r++) begin
				@(posedge phy_mdc_o);
				bits = {bits[62:0], phy_mdio_o};
				if (r == 35)
					rd_op = (bits[1:0] == 2'b10);
				if (r == 45)
					regad = bits[4:0];
				if (rd_op && r >= 46) begin
					assert (!phy_mdio_oe_o)
					else abort_run($sformatf("Mismatch at time %0t: %s", $time,
							"controller drives MDIO after turnaround of a read"));
				end
				#2;
				if (rd_op && r >= 47 && r < 63)
					phy_mdio_i = phy_regs[regad][62 - r]; // Sampled at the next rise
			end
			phy_mdio_i = 1'b0;
			if (!rd_op)
				phy_regs[bits[22:18]] = bits[15:0];
			last_frame = bits;
			frame_count++;
		end
	end

	bresp_hold: assert property (@(posedge aclk) disable iff (reset_i)
		(s_bvalid_o && !s_bready_i) |=> (s_bvalid_o && $stable(s_bresp_o)))
		else abort_run($sformatf("Mismatch at time %0t: write response not held", $time));

	rdata_hold: assert property (@(posedge aclk) disable iff (reset_i)
		(s_rvalid_o && !s_rready_i) |=> (s_rvalid_o && $stable(s_rdata_o)))
		else abort_run($sformatf("Mismatch at time %0t: read data not held", $time));

	mdio_owner: assert property (@(posedge aclk) disable iff (reset_i)
		phy_mdio_oe_o |-> (phy_mdio_req_o && phy_mdio_gnt_i))
		else abort_run($sformatf("Mismatch at time %0t: MDIO driven without grant", $time));

	initial begin
		logic [31:0] rdata;
		logic [31:0] mdic;
		logic [15:0] wr_data;
		int          frames_before;
		reset_i      = 1'b1;
		s_awaddr_i   = '0;
		s_awvalid_i  = 1'b0;
		s_wdata_i    = '0;
		s_wstrb_i    = '1;
		s_wvalid_i   = 1'b0;
		s_bready_i   = 1'b1;
		s_araddr_i   = '0;
		s_arvalid_i  = 1'b0;
		s_rready_i   = 1'b1;
		phy_int_i    = 1'b0;
		phy_lsc_i    = 1'b0;
		phy_speed_i  = 2'b10;
		phy_duplex_i = 1'b1;
		phy_up_i     = 1'b1;
		seed = 32'h2247_62a3;
		for (int a = 0; a < 32; a++)
			phy_regs[a] = 16'($random(seed));

		repeat (4) @(posedge aclk);
		#1;
		check_value("phy_reset_o in reset", phy_reset_o, 1);
		check_value("bvalid in reset", s_bvalid_o, 0);
		check_value("rvalid in reset", s_rvalid_o, 0);
		check_value("MDIO request in reset", phy_mdio_req_o, 0);
		check_value("MDIO enable in reset", phy_mdio_oe_o, 0);
		check_value("MDC in reset", phy_mdc_o, 0);
		#1;
		reset_i = 1'b0;
		#1;
		check_value("intr_request_o", intr_request_o, 0);
		check_value("reset_request_o", reset_request_o, 0);
		check_value("phy_reset_o", phy_reset_o, 0);
		idle_cycles(1);

		read_reg(REG_STATUS, rdata, 0);
		check_value("STATUS", rdata, status_word(2'b10, 1'b1, 1'b1));
		phy_speed_i = 2'b01;
		phy_up_i    = 1'b0;
		read_reg(REG_STATUS, rdata, 0);
		check_value("STATUS", rdata, status_word(2'b01, 1'b0, 1'b1));
		read_reg(32'h0000_0100, rdata, 0);
		check_value("unmapped read", rdata, 0);

		write_reg(REG_CTRL, 32'h1 << CTRL_RST_BIT, 0);
		check_value("reset_request_o", reset_request_o, 1);
		check_value("phy_reset_o", phy_reset_o, 0);
		write_reg(REG_CTRL, 32'h1 << CTRL_PHY_RST_BIT, 0);
		check_value("reset_request_o", reset_request_o, 0);
		check_value("phy_reset_o", phy_reset_o, 1);
		write_reg(REG_CTRL, 32'h0, 0);
		check_value("phy_reset_o", phy_reset_o, 0);

		// MDIO write to PHY register 7
		wr_data = 16'($random(seed));
		frames_before = frame_count;
		write_reg(REG_MDIC, mdic_word(2'b01, 5'd7, wr_data), 0);
		wait_mdic_ready(mdic);
		check_value("MDIO frame count", frame_count, frames_before + 1);
		check_value("MDIO preamble", last_frame[63:32], 32'hFFFF_FFFF);
		check_value("MDIO write frame", last_frame[31:0],
				{2'b01, 2'b01, PHY_ADDR, 5'd7, 2'b10, wr_data});
		check_value("MDIC error bit", mdic[MDIC_ERR_BIT], 0);
		check_value("MDIC data", mdic[15:0], wr_data);
		read_reg(REG_ICR, rdata, 0);
		check_value("ICR after MDIO write", rdata, 32'h1 << ICR_MDAC_BIT);
		read_reg(REG_ICR, rdata, 0);
		check_value("ICR after clear", rdata, 0);

		write_reg(REG_MDIC, mdic_word(2'b10, 5'd9, 16'h0), 0);
		wait_mdic_ready(mdic);
		check_value("MDIC read data", mdic[15:0], phy_regs[9]);
		check_value("MDIC error bit", mdic[MDIC_ERR_BIT], 0);
		read_reg(REG_ICR, rdata, 0);
		check_value("ICR after MDIO read", rdata, 32'h1 << ICR_MDAC_BIT);

		frames_before = frame_count;
		write_reg(REG_MDIC, mdic_word(2'b00, 5'd5, 16'h1234), 0);
		read_reg(REG_MDIC, mdic, 0);
		check_value("MDIC ready on bad op", mdic[MDIC_RDY_BIT], 1);
		check_value("MDIC error on bad op", mdic[MDIC_ERR_BIT], 1);
		check_value("MDIO request on bad op", phy_mdio_req_o, 0);
		check_value("MDIO frame count", frame_count, frames_before);

		// Link change pulse while still masked
		phy_lsc_i = 1'b1;
		idle_cycles(1);
		phy_lsc_i = 1'b0;
		for (int i = 0; i < 4; i++) begin
			#1;
			check_value("intr_request_o while masked", intr_request_o, 0);
			@(posedge aclk);
			#2;
		end
		write_reg(REG_IMS, 32'h1 << ICR_LSC_BIT, 0);
		check_value("intr_request_o after IMS", intr_request_o, 1);
		read_reg(REG_IMS, rdata, 0);
		check_value("IMS", rdata, 32'h1 << ICR_LSC_BIT);
		read_reg(REG_ICR, rdata, 0);
		check_value("ICR link change", rdata, 32'h1 << ICR_LSC_BIT);
		check_value("intr_request_o after ICR read", intr_request_o, 0);

		write_reg(REG_ICS, 32'h1 << ICR_PHYINT_BIT, 0);
		check_value("intr_request_o after ICS", intr_request_o, 0);
		write_reg(REG_IMS, 32'h1 << ICR_PHYINT_BIT, 0);
		check_value("intr_request_o unmasked", intr_request_o, 1);
		write_reg(REG_IMC, (32'h1 << ICR_PHYINT_BIT) | (32'h1 << ICR_LSC_BIT), 0);
		check_value("intr_request_o after IMC", intr_request_o, 0);
		read_reg(REG_IMS, rdata, 0);
		check_value("IMS after IMC", rdata, 0);
		read_reg(REG_ICR, rdata, 0);
		check_value("ICR after ICS", rdata, 32'h1 << ICR_PHYINT_BIT);

		phy_int_i = 1'b1;
		idle_cycles(1);
		phy_int_i = 1'b0;
		idle_cycles(4);
		read_reg(REG_ICR, rdata, 0);
		check_value("ICR PHY interrupt", rdata, 32'h1 << ICR_PHYINT_BIT);

		// Back-pressure on both response channels
		write_reg(REG_IMS, 32'h1 << ICR_PHYINT_BIT, 6);
		read_reg(REG_IMS, rdata, 6);
		check_value("IMS under back-pressure", rdata, 32'h1 << ICR_PHYINT_BIT);

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: e1000_top.sv
module e1000_top
	import e1000_pkg::*;
(
	input  logic                     aclk,
	input  logic                     reset_i,

	input  logic [AXIL_ADDR_W-1:0]   s_awaddr_i,
	input  logic                     s_awvalid_i,
	output logic                     s_awready_o,
	input  logic [AXIL_DATA_W-1:0]   s_wdata_i,
	input  logic [AXIL_DATA_W/8-1:0] s_wstrb_i,
	input  logic                     s_wvalid_i,
	output logic                     s_wready_o,
	output logic [1:0]               s_bresp_o,
	output logic                     s_bvalid_o,
	input  logic                     s_bready_i,
	input  logic [AXIL_ADDR_W-1:0]   s_araddr_i,
	input  logic                     s_arvalid_i,
	output logic                     s_arready_o,
	output logic [AXIL_DATA_W-1:0]   s_rdata_o,
	output logic [1:0]               s_rresp_o,
	output logic                     s_rvalid_o,
	input  logic                     s_rready_i,

	output logic                     intr_request_o,
	output logic                     reset_request_o,

	output logic                     phy_mdc_o,
	input  logic                     phy_mdio_i,
	output logic                     phy_mdio_o,
	output logic                     phy_mdio_oe_o,
	output logic                     phy_mdio_req_o,
	input  logic                     phy_mdio_gnt_i,

	input  logic                     phy_int_i,
	input  logic                     phy_lsc_i,
	output logic                     phy_reset_o,
	input  logic [1:0]               phy_speed_i,
	input  logic                     phy_duplex_i,
	input  logic                     phy_up_i
);

	logic        ics_wr;
	logic        ims_wr;
	logic        imc_wr;
	logic        icr_rd;
	logic [31:0] reg_wdata;
	logic [31:0] icr;
	logic        mdio_start;
	mdio_op_e    mdio_op;
	logic [4:0]  mdio_regad;
	logic [15:0] mdio_wdata;
	logic [15:0] mdio_rdata;
	logic        mdio_done;

	// AXI and PHY status pins connect by name
	e1000_regs e1000_regs_inst (
		.icr_i        (icr),
		.ics_wr_o     (ics_wr),
		.ims_wr_o     (ims_wr),
		.imc_wr_o     (imc_wr),
		.icr_rd_o     (icr_rd),
		.reg_wdata_o  (reg_wdata),
		.mdio_start_o (mdio_start),
		.mdio_op_o    (mdio_op),
		.mdio_regad_o (mdio_regad),
		.mdio_wdata_o (mdio_wdata),
		.mdio_rdata_i (mdio_rdata),
		.mdio_done_i  (mdio_done),
		.*
	);

	intr_ctrl intr_ctrl_inst (
		.mdac_i      (mdio_done), // MDIO completion is the MDAC cause
		.ics_wr_i    (ics_wr),
		.ims_wr_i    (ims_wr),
		.imc_wr_i    (imc_wr),
		.icr_rd_i    (icr_rd),
		.reg_wdata_i (reg_wdata),
		.icr_o       (icr),
		.*
	);

	shift_mdio shift_mdio_inst (
		.start_i (mdio_start),
		.op_i    (mdio_op),
		.regad_i (mdio_regad),
		.wdata_i (mdio_wdata),
		.rdata_o (mdio_rdata),
		.done_o  (mdio_done),
		.*
	);

endmodule

// File: shift_mdio.sv
module shift_mdio
	import e1000_pkg::*;
(
	input  logic        aclk,
	input  logic        reset_i,

	input  logic        start_i,
	input  mdio_op_e    op_i,
	input  logic [4:0]  regad_i,
	input  logic [15:0] wdata_i,
	output logic [15:0] rdata_o,
	output logic        done_o,

	output logic        phy_mdc_o,
	output logic        phy_mdio_o,
	output logic        phy_mdio_oe_o,
	input  logic        phy_mdio_i,
	output logic        phy_mdio_req_o,
	input  logic        phy_mdio_gnt_i
);

	mdio_state_e           state;
	logic [MDIO_DIV_W-1:0] div_cnt;
	logic [4:0]            bit_cnt;
	logic [31:0]           shreg;
	logic                  is_read;
	logic                  mdc_q;
	logic                  half_end;

	assign half_end  = (div_cnt == MDIO_DIV_W'(MDIO_HALF_DIV - 1));
	assign phy_mdc_o = mdc_q;

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			state          <= MDIO_IDLE;
			mdc_q          <= 1'b0;
			phy_mdio_o     <= 1'b0;
			phy_mdio_oe_o  <= 1'b0;
			phy_mdio_req_o <= 1'b0;
			done_o         <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				MDIO_IDLE: if (start_i) begin
					shreg          <= {2'b01, op_i, PHY_ADDR, regad_i, 2'b10, wdata_i};
					is_read        <= (op_i == MDIO_OP_READ);
					phy_mdio_req_o <= 1'b1;
					state          <= MDIO_REQ;
				end
				MDIO_REQ: if (phy_mdio_gnt_i) begin
					div_cnt       <= '0;
					bit_cnt       <= 5'(MDIO_PREAMBLE_BITS - 1);
					mdc_q         <= 1'b0;
					phy_mdio_o    <= 1'b1; // Preamble is all ones
					phy_mdio_oe_o <= 1'b1;
					state         <= MDIO_PRE;
				end
				MDIO_PRE, MDIO_SHIFT: begin
					div_cnt <= div_cnt + 1'b1;
					if (half_end) begin
						div_cnt <= '0;
						mdc_q   <= ~mdc_q;
						if (!mdc_q) begin
							// Rising edge where PHY data is stable
							if (state == MDIO_SHIFT && is_read && bit_cnt < 5'd16)
								rdata_o <= {rdata_o[14:0], phy_mdio_i};
						end else if (bit_cnt != 5'd0) begin
							bit_cnt <= bit_cnt - 1'b1;
							if (state == MDIO_SHIFT) begin
								phy_mdio_o <= shreg[31];
								shreg      <= {shreg[30:0], 1'b0};
								if (is_read && bit_cnt == 5'd18)
									phy_mdio_oe_o <= 1'b0; // PHY owns the line from TA on
							end
						end else if (state == MDIO_PRE) begin
							bit_cnt    <= 5'd31;
							phy_mdio_o <= shreg[31];
							shreg      <= {shreg[30:0], 1'b0};
							state      <= MDIO_SHIFT;
						end else begin
							phy_mdio_o    <= 1'b0;
							phy_mdio_oe_o <= 1'b0;
							state         <= MDIO_DONE;
						end
					end
				end
				MDIO_DONE: begin
					phy_mdio_req_o <= 1'b0;
					done_o         <= 1'b1;
					state          <= MDIO_IDLE;
				end
				default: state <= MDIO_IDLE;
			endcase
		end
	end

endmodule

// File: intr_ctrl.sv
module intr_ctrl
	import e1000_pkg::*;
(
	input  logic        aclk,
	input  logic        reset_i,

	input  logic        phy_int_i,
	input  logic        phy_lsc_i,
	input  logic        mdac_i,

	input  logic        ics_wr_i,
	input  logic        ims_wr_i,
	input  logic        imc_wr_i,
	input  logic        icr_rd_i,
	input  logic [31:0] reg_wdata_i,

	output logic [31:0] icr_o,
	output logic        intr_request_o
);

	logic [1:0]  int_sync;
	logic [1:0]  lsc_sync;
	logic [31:0] cause_set;
	logic [31:0] mask_q;

	// PHY pins are asynchronous to aclk
	always_ff @(posedge aclk) begin
		if (reset_i) begin
			int_sync <= '0;
			lsc_sync <= '0;
		end else begin
			int_sync <= {int_sync[0], phy_int_i};
			lsc_sync <= {lsc_sync[0], phy_lsc_i};
		end
	end

	always_comb begin
		cause_set = ics_wr_i ? reg_wdata_i : '0;
		cause_set[ICR_LSC_BIT]    = cause_set[ICR_LSC_BIT] | lsc_sync[1];
		cause_set[ICR_PHYINT_BIT] = cause_set[ICR_PHYINT_BIT] | int_sync[1];
		cause_set[ICR_MDAC_BIT]   = cause_set[ICR_MDAC_BIT] | mdac_i;
	end

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			icr_o  <= '0;
			mask_q <= '0;
		end else begin
			icr_o <= (icr_rd_i ? '0 : icr_o) | cause_set; // New cause survives the clear
			if (ims_wr_i)
				mask_q <= mask_q | reg_wdata_i;
			else if (imc_wr_i)
				mask_q <= mask_q & ~reg_wdata_i;
		end
	end

	assign intr_request_o = |(icr_o & mask_q);

endmodule

// File: e1000_regs.sv
module e1000_regs
	import e1000_pkg::*;
(
	input  logic                     aclk,
	input  logic                     reset_i,

	input  logic [AXIL_ADDR_W-1:0]   s_awaddr_i,
	input  logic                     s_awvalid_i,
	output logic                     s_awready_o,
	input  logic [AXIL_DATA_W-1:0]   s_wdata_i,
	input  logic [AXIL_DATA_W/8-1:0] s_wstrb_i,
	input  logic                     s_wvalid_i,
	output logic                     s_wready_o,
	output logic [1:0]               s_bresp_o,
	output logic                     s_bvalid_o,
	input  logic                     s_bready_i,
	input  logic [AXIL_ADDR_W-1:0]   s_araddr_i,
	input  logic                     s_arvalid_i,
	output logic                     s_arready_o,
	output logic [AXIL_DATA_W-1:0]   s_rdata_o,
	output logic [1:0]               s_rresp_o,
	output logic                     s_rvalid_o,
	input  logic                     s_rready_i,

	input  logic [1:0]               phy_speed_i,
	input  logic                     phy_duplex_i,
	input  logic                     phy_up_i,

	input  logic [31:0]              icr_i,
	output logic                     ics_wr_o,
	output logic                     ims_wr_o,
	output logic                     imc_wr_o,
	output logic                     icr_rd_o,
	output logic [31:0]              reg_wdata_o,

	output logic                     mdio_start_o,
	output mdio_op_e                 mdio_op_o,
	output logic [4:0]               mdio_regad_o,
	output logic [15:0]              mdio_wdata_o,
	input  logic [15:0]              mdio_rdata_i,
	input  logic                     mdio_done_i,

	output logic                     reset_request_o,
	output logic                     phy_reset_o
);

	logic                   wr_hs;
	logic                   rd_hs;
	logic                   bvalid_q;
	logic                   rvalid_q;
	logic [AXIL_DATA_W-1:0] wmask;
	logic [AXIL_DATA_W-1:0] wdata_m;
	logic [AXIL_DATA_W-1:0] rd_mux;
	logic [31:0]            ctrl_q;
	logic [31:0]            ims_q;
	logic [15:0]            mdic_data;
	logic [4:0]             mdic_regad;
	logic [1:0]             mdic_op;
	logic                   mdic_rdy;
	logic                   mdic_err;

	// Both channels taken together, only with no response outstanding
	assign wr_hs = s_awvalid_i & s_wvalid_i & ~bvalid_q;
	assign s_awready_o = wr_hs;
	assign s_wready_o  = wr_hs;
	assign s_bvalid_o  = bvalid_q;
	assign s_bresp_o   = 2'b00;

	assign rd_hs = s_arvalid_i & ~rvalid_q;
	assign s_arready_o = ~rvalid_q;
	assign s_rvalid_o  = rvalid_q;
	assign s_rresp_o   = 2'b00;
	assign icr_rd_o    = rd_hs & (s_araddr_i == REG_ICR); // Clears on the capture edge

	assign reset_request_o = ctrl_q[CTRL_RST_BIT];
	assign phy_reset_o     = ctrl_q[CTRL_PHY_RST_BIT] | reset_i;

	assign mdio_op_o    = mdio_op_e'(mdic_op);
	assign mdio_regad_o = mdic_regad;
	assign mdio_wdata_o = mdic_data;

	always_comb begin
		for (int i = 0; i < AXIL_DATA_W/8; i++) begin
			wmask[8*i +: 8] = {8{s_wstrb_i[i]}};
		end
		wdata_m = s_wdata_i & wmask;
	end

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			bvalid_q     <= 1'b0;
			ctrl_q       <= '0;
			ims_q        <= '0;
			ics_wr_o     <= 1'b0;
			ims_wr_o     <= 1'b0;
			imc_wr_o     <= 1'b0;
			mdio_start_o <= 1'b0;
			mdic_data    <= '0;
			mdic_regad   <= '0;
			mdic_op      <= '0;
			mdic_rdy     <= 1'b1;
			mdic_err     <= 1'b0;
		end else begin
			ics_wr_o     <= wr_hs && (s_awaddr_i == REG_ICS);
			ims_wr_o     <= wr_hs && (s_awaddr_i == REG_IMS);
			imc_wr_o     <= wr_hs && (s_awaddr_i == REG_IMC);
			mdio_start_o <= 1'b0;

			if (mdio_done_i) begin
				mdic_rdy <= 1'b1;
				if (mdic_op == MDIO_OP_READ)
					mdic_data <= mdio_rdata_i;
			end

			if (wr_hs) begin
				bvalid_q    <= 1'b1;
				reg_wdata_o <= wdata_m;
				case (s_awaddr_i)
					REG_CTRL: ctrl_q <= (ctrl_q & ~wmask) | wdata_m;
					REG_MDIC: if (mdic_rdy) begin // Busy transfer blocks new requests
						mdic_data  <= wdata_m[15:0];
						mdic_regad <= wdata_m[MDIC_REGAD_LSB +: 5];
						mdic_op    <= wdata_m[MDIC_OP_LSB +: 2];
						if (wdata_m[MDIC_OP_LSB +: 2] == MDIO_OP_WRITE ||
								wdata_m[MDIC_OP_LSB +: 2] == MDIO_OP_READ) begin
							mdic_rdy     <= 1'b0;
							mdic_err     <= 1'b0;
							mdio_start_o <= 1'b1;
						end else begin
							mdic_rdy <= 1'b1; // Bad opcode completes at once
							mdic_err <= 1'b1;
						end
					end
					REG_IMS: ims_q <= ims_q | wdata_m;
					REG_IMC: ims_q <= ims_q & ~wdata_m;
					default: ;
				endcase
			end else if (s_bready_i) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	always_comb begin
		rd_mux = '0;
		case (s_araddr_i)
			REG_CTRL: rd_mux = ctrl_q;
			REG_STATUS: begin
				rd_mux[STATUS_FD_BIT]           = phy_duplex_i;
				rd_mux[STATUS_LU_BIT]           = phy_up_i;
				rd_mux[STATUS_SPEED_LSB +: 2]   = phy_speed_i;
			end
			REG_MDIC: begin
				rd_mux[15:0]                  = mdic_data;
				rd_mux[MDIC_REGAD_LSB +: 5]   = mdic_regad;
				rd_mux[MDIC_OP_LSB +: 2]      = mdic_op;
				rd_mux[MDIC_RDY_BIT]          = mdic_rdy;
				rd_mux[MDIC_ERR_BIT]          = mdic_err;
			end
			REG_ICR: rd_mux = icr_i;
			REG_IMS: rd_mux = ims_q;
			default: ;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			rvalid_q <= 1'b0;
		end else if (rd_hs) begin
			rvalid_q  <= 1'b1;
			s_rdata_o <= rd_mux;
		end else if (s_rready_i) begin
			rvalid_q <= 1'b0;
		end
	end

endmodule

// File: e1000_pkg.sv
package e1000_pkg;

	// Register port widths
	localparam int AXIL_ADDR_W = 32;
	localparam int AXIL_DATA_W = 32;

	// Register offsets
	localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 32'h0000_0000;
	localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 32'h0000_0008;
	localparam logic [AXIL_ADDR_W-1:0] REG_MDIC   = 32'h0000_0020;
	localparam logic [AXIL_ADDR_W-1:0] REG_ICR    = 32'h0000_00C0;
	localparam logic [AXIL_ADDR_W-1:0] REG_ICS    = 32'h0000_00C8;
	localparam logic [AXIL_ADDR_W-1:0] REG_IMS    = 32'h0000_00D0;
	localparam logic [AXIL_ADDR_W-1:0] REG_IMC    = 32'h0000_00D8;

	localparam int CTRL_RST_BIT     = 26;
	localparam int CTRL_PHY_RST_BIT = 31;

	localparam int STATUS_FD_BIT    = 0;
	localparam int STATUS_LU_BIT    = 1;
	localparam int STATUS_SPEED_LSB = 6;

	// Interrupt causes
	localparam int ICR_LSC_BIT    = 2;
	localparam int ICR_MDAC_BIT   = 9;
	localparam int ICR_PHYINT_BIT = 12;

	// MDIC data sits in 15:0 and the PHY address in 25:21 is ignored
	localparam int MDIC_REGAD_LSB = 16;
	localparam int MDIC_OP_LSB    = 26;
	localparam int MDIC_RDY_BIT   = 28;
	localparam int MDIC_ERR_BIT   = 30;

	localparam logic [4:0] PHY_ADDR = 5'b00000;
	localparam int MDIO_HALF_DIV      = 4; // aclk cycles per MDC half period
	localparam int MDIO_DIV_W         = $clog2(MDIO_HALF_DIV);
	localparam int MDIO_PREAMBLE_BITS = 32;

	typedef enum logic [1:0] {
		MDIO_OP_WRITE = 2'b01,
		MDIO_OP_READ  = 2'b10
	} mdio_op_e;

	typedef enum logic [2:0] {
		MDIO_IDLE,
		MDIO_REQ,
		MDIO_PRE,
		MDIO_SHIFT,
		MDIO_DONE
	} mdio_state_e;

endpackage
